//--- Makefile
# Verilator flow for the timer subsystem testbench

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module tb_timer_subsys -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- bench/tb_timer_subsys.sv
`timescale 1ns/1ps

module tb_timer_subsys import periph_pkg::*; ();

  localparam int unsigned TIMEOUT    = 200;
  localparam int unsigned GOLD_LINES = 64;
  localparam int unsigned BURST_LEN  = 6;
  localparam int          ERR_SRC    = NUM_TIMERS;

  typedef struct packed {
    logic     chk;
    tmr_rsp_t rsp;
  } exp_rsp_t;

  logic                  clock;
  logic                  rst_i;
  logic                  host_req_valid_i;
  tmr_req_t              host_req_i;
  logic                  host_credit_o;
  logic                  host_rsp_valid_o;
  tmr_rsp_t              host_rsp_o;
  logic [NUM_TIMERS-1:0] irq_o;

  data_t                 gold [GOLD_LINES*6];
  exp_rsp_t              exp_q [NUM_SRC][$];
  int                    credits;
  int                    errors;
  data_t                 last_data;
  logic [NUM_TIMERS-1:0] irq_allow;

  initial clock = 1'b0;
  always #50 clock = ~clock;

  timer_subsys_top u_dut (
    .clock            (clock),
    .rst_i            (rst_i),
    .host_req_valid_i (host_req_valid_i),
    .host_req_i       (host_req_i),
    .host_credit_o    (host_credit_o),
    .host_rsp_valid_o (host_rsp_valid_o),
    .host_rsp_o       (host_rsp_o),
    .irq_o            (irq_o)
  );

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("ERROR: timed out waiting for %s at %0t", what, $time);
    $display("checks done, errors: %0d", errors);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string name, input data_t got, input data_t want);
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
    errors++;
  endtask

  function automatic exp_rsp_t make_exp(input logic chk, input data_t data, input logic err);
    exp_rsp_t e;
    e.chk      = chk;
    e.rsp.data = data;
    e.rsp.err  = err;
    return e;
  endfunction

  // index 0 to 3 with clear high bits is a timer and anything else the error path
  function automatic int src_of(input addr_t addr);
    if (addr[7:5] == 3'b000 && int'(addr[4:2]) < NUM_TIMERS) begin
      return int'(addr[4:2]);
    end
    return ERR_SRC;
  endfunction

  function automatic int pending_rsps();
    int n;
    n = 0;
    for (int s = 0; s < NUM_SRC; s++) begin
      n += exp_q[s].size();
    end
    return n;
  endfunction

  task automatic send_req(input logic write, input addr_t addr, input data_t data,
                          input exp_rsp_t want);
    int unsigned wait_cnt;
    wait_cnt = 0;
    while (credits == 0) begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > TIMEOUT) abort_run("a host credit");
    end
    exp_q[src_of(addr)].push_back(want);
    host_req_valid_i = 1'b1;
    host_req_i.write = write;
    host_req_i.addr  = addr;
    host_req_i.data  = data;
    credits--;
    next_cycle();
    host_req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int unsigned wait_cnt;
    wait_cnt = 0;
    while (pending_rsps() != 0) begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > TIMEOUT) abort_run("outstanding responses");
    end
  endtask

  task automatic wait_irq(input logic [NUM_TIMERS-1:0] want);
    int unsigned wait_cnt;
    wait_cnt = 0;
    while (irq_o !== want) begin
      next_cycle();
      wait_cnt++;
      if (wait_cnt > TIMEOUT) abort_run("the irq vector");
    end
  endtask

  // two COUNT reads that are either equal or nondecreasing
  task automatic count_pair(input addr_t addr, input logic equal);
    data_t first;
    send_req(1'b0, addr, '0, make_exp(1'b0, '0, 1'b0));
    wait_drain();
    first = last_data;
    send_req(1'b0, addr, '0, make_exp(1'b0, '0, 1'b0));
    wait_drain();
    if (equal) begin
      assert (last_data == first)
      else report_mismatch("host_rsp_o.data (frozen count)", last_data, first);
    end else begin
      assert (last_data >= first)
      else report_mismatch("host_rsp_o.data (count at least)", last_data, first);
    end
  endtask

  // only one source is ever outstanding, so the first busy queue owns the reply
  task automatic check_response();
    exp_rsp_t want;
    int       src;
    src = -1;
    for (int s = int'(NUM_SRC) - 1; s >= 0; s--) begin
      if (exp_q[s].size() != 0) src = s;
    end
    assert (src >= 0) else begin
      $display("ERROR: response arrived with no request outstanding at %0t", $time);
      errors++;
    end
    if (src >= 0) begin
      want = exp_q[src].pop_front();
      if (want.chk) begin
        assert (host_rsp_o.data == want.rsp.data)
        else report_mismatch("host_rsp_o.data", host_rsp_o.data, want.rsp.data);
        assert (host_rsp_o.err == want.rsp.err)
        else report_mismatch("host_rsp_o.err", data_t'(host_rsp_o.err), data_t'(want.rsp.err));
      end
      last_data = host_rsp_o.data;
    end
  endtask

  // mid-cycle sampling of credits, responses and irq
  initial begin
    forever begin
      @(negedge clock);
      if (!rst_i) begin
        if (host_credit_o) begin
          credits++;
          assert (credits <= HOST_CREDITS) else begin
            $display("ERROR: host credits rose to %0d at %0t", credits, $time);
            errors++;
          end
        end
        assert ((irq_o & ~irq_allow) == '0)
        else report_mismatch("irq_o", data_t'(irq_o), data_t'(irq_o & irq_allow));
        if (host_rsp_valid_o) check_response();
      end
    end
  end

  task automatic run_golden();
    int unsigned base;
    int unsigned gap;
    logic [3:0]  op;
    addr_t       addr;
    data_t       wdata;
    data_t       edata;
    logic        eerr;
    for (int unsigned idx = 0; idx < GOLD_LINES; idx++) begin
      base      = idx * 6;
      op        = gold[base][3:0];
      if (op == 4'hf) break;
      addr      = gold[base + 1][7:0];
      wdata     = gold[base + 2];
      edata     = gold[base + 3];
      eerr      = gold[base + 4][0];
      irq_allow = gold[base + 5][NUM_TIMERS-1:0];
      case (op)
        4'h0, 4'h1: begin
          send_req(op == 4'h0, addr, wdata, make_exp(1'b1, edata, eerr));
          wait_drain();
        end
        4'h2: begin
          // writes and read-backs alternate on one register
          for (int i = 0; i < BURST_LEN; i++) begin
            if (i % 2 == 0) begin
              send_req(1'b1, addr, wdata + data_t'(i), make_exp(1'b1, '0, 1'b0));
            end else begin
              send_req(1'b0, addr, '0, make_exp(1'b1, wdata + data_t'(i - 1), 1'b0));
            end
          end
          wait_drain();
        end
        4'h3: wait_irq(edata[NUM_TIMERS-1:0]);
        4'h4: count_pair(addr, edata[0]);
        4'h5: begin
          for (int t = 0; t < NUM_TIMERS; t++) begin
            for (int r = 0; r < 4; r++) begin
              send_req(1'b0, addr_t'(t * 4 + r), '0, make_exp(1'b1, edata, eerr));
            end
            wait_drain();
          end
        end
        default: begin
          $display("ERROR: unknown golden op %h on line %0d", op, idx);
          errors++;
        end
      endcase
      gap = $urandom % 4;
      repeat (gap) next_cycle();
    end
  endtask

  initial begin
    int unsigned seed;
    seed             = $urandom(45);
    errors           = 0;
    credits          = HOST_CREDITS;
    irq_allow        = '0;
    last_data        = '0;
    rst_i            = 1'b1;
    host_req_valid_i = 1'b0;
    host_req_i       = '0;
    $readmemh("bench/timer_golden.txt", gold);
    repeat (5) @(posedge clock);
    #1;
    rst_i = 1'b0;
    assert (irq_o == '0 && !host_rsp_valid_o && !host_credit_o) else begin
      $display("ERROR: outputs not idle right after reset at %0t", $time);
      errors++;
    end
    run_golden();
    wait_drain();
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- bench/timer_golden.txt
// columns are op addr wdata expdata experr irq_mask
// ops 0 write 1 read 2 burst 3 wait irq 4 count pair 5 sweep f end
5 00 00000000 00000000 0 0
0 01 1234abcd 00000000 0 0
0 05 89abcdef 00000000 0 0
0 09 0badf00d 00000000 0 0
0 0d 7fff0000 00000000 0 0
0 00 a5a50000 00000000 0 0
0 04 5a5a0002 00000000 0 0
0 08 00c0ffee 00000000 0 0
0 0c 13570240 00000000 0 0
1 01 00000000 1234abcd 0 0
1 05 00000000 89abcdef 0 0
1 09 00000000 0badf00d 0 0
1 0d 00000000 7fff0000 0 0
1 00 00000000 a5a50000 0 0
1 04 00000000 5a5a0002 0 0
1 08 00000000 00c0ffee 0 0
1 0c 00000000 13570240 0 0
0 10 ffffffff 00000000 1 0
1 1f 00000000 00000000 1 0
0 20 ffffffff 00000000 1 0
0 84 ffffffff 00000000 1 0
1 e3 00000000 00000000 1 0
1 00 00000000 a5a50000 0 0
1 04 00000000 5a5a0002 0 0
0 09 00000005 00000000 0 0
0 0a 00000000 00000000 0 0
0 08 00000001 00000000 0 4
3 00 00000000 00000004 0 4
0 08 00000000 00000000 0 4
1 0b 00000000 00000001 0 4
0 0b 00000001 00000000 0 4
3 00 00000000 00000000 0 4
1 0b 00000000 00000000 0 0
0 06 00000000 00000000 0 0
0 04 00000001 00000000 0 0
4 06 00000000 00000000 0 0
0 04 00000000 00000000 0 0
4 06 00000000 00000001 0 0
2 0d 00001000 00000000 0 0
f 00 00000000 00000000 0 0

//--- filelist.f
source/periph_pkg.sv
source/timer_req_decoder.sv
source/timer_unit.sv
source/timer_resp_merge.sv
source/timer_subsys_top.sv
bench/tb_timer_subsys.sv

//--- source/periph_pkg.sv
package periph_pkg;

  // subsystem sizing
  localparam int unsigned NUM_TIMERS    = 4;
  localparam int unsigned IDX_W         = 3;
  localparam int unsigned HOST_CREDITS  = 2;
  localparam int unsigned TIMER_CREDITS = 2;

  // address layout of high bits, timer index and register offset
  localparam int unsigned ADDR_W  = 8;
  localparam int unsigned OFF_W   = 2;
  localparam int unsigned IDX_LSB = OFF_W;
  localparam int unsigned HI_LSB  = IDX_LSB + IDX_W;

  // merger sources are the timers plus the decoder error path
  localparam int unsigned NUM_SRC = NUM_TIMERS + 1;
  localparam int unsigned SRC_W   = $clog2(NUM_SRC);

  // host buffer, response queue and credit counter widths
  localparam int unsigned HBUF_PTR_W = $clog2(HOST_CREDITS);
  localparam int unsigned HBUF_CNT_W = $clog2(HOST_CREDITS + 1);
  localparam int unsigned RQ_PTR_W   = $clog2(TIMER_CREDITS);
  localparam int unsigned RQ_CNT_W   = $clog2(TIMER_CREDITS + 1);
  localparam int unsigned CRED_W     = $clog2(TIMER_CREDITS + 1);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [31:0]           data_t;
  typedef logic [IDX_W-1:0]      tmr_idx_t;
  typedef logic [OFF_W-1:0]      reg_off_t;
  typedef logic [SRC_W-1:0]      src_idx_t;
  typedef logic [HBUF_PTR_W-1:0] hbuf_ptr_t;
  typedef logic [HBUF_CNT_W-1:0] hbuf_cnt_t;
  typedef logic [RQ_PTR_W-1:0]   rq_ptr_t;
  typedef logic [RQ_CNT_W-1:0]   rq_cnt_t;
  typedef logic [CRED_W-1:0]     cred_t;

  // register offsets inside one timer
  localparam reg_off_t REG_CTRL    = 2'd0;
  localparam reg_off_t REG_COMPARE = 2'd1;
  localparam reg_off_t REG_COUNT   = 2'd2;
  localparam reg_off_t REG_STATUS  = 2'd3;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } tmr_req_t;

  typedef struct packed {
    data_t data;
    logic  err;
  } tmr_rsp_t;

  function automatic tmr_idx_t addr_idx(addr_t addr);
    return addr[IDX_LSB +: IDX_W];
  endfunction

  function automatic reg_off_t addr_off(addr_t addr);
    return addr[OFF_W-1:0];
  endfunction

  // upper address bits must be clear for a mapped access
  function automatic logic addr_hi_zero(addr_t addr);
    return (addr[ADDR_W-1:HI_LSB] == '0);
  endfunction

endpackage

//--- source/timer_req_decoder.sv
`timescale 1ns/1ps

module timer_req_decoder import periph_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_i,
  input  logic                  host_req_valid_i,
  input  tmr_req_t              host_req_i,
  output logic                  host_credit_o,
  output logic [NUM_TIMERS-1:0] req_valid_o,
  output tmr_req_t              req_o,
  input  logic [NUM_TIMERS-1:0] credit_ret_i,
  output logic                  err_valid_o,
  output tmr_rsp_t              err_rsp_o,
  input  logic                  err_pop_i
);

  // host request buffer
  tmr_req_t  buf_mem [HOST_CREDITS];
  hbuf_ptr_t wr_ptr;
  hbuf_ptr_t rd_ptr;
  hbuf_cnt_t buf_cnt;

  // credits held towards each timer
  cred_t     credit [NUM_TIMERS];

  tmr_req_t  head;
  logic      head_valid;
  tmr_idx_t  head_idx;
  logic      head_mapped;
  logic      err_free;
  logic      fwd;
  logic      err_take;
  logic      pop;

  assign head        = buf_mem[rd_ptr];
  assign head_valid  = (buf_cnt != '0);
  assign head_idx    = addr_idx(head.addr);
  assign head_mapped = addr_hi_zero(head.addr) && (32'(head_idx) < NUM_TIMERS);

  // forward only to the addressed timer, and only with credit left
  always_comb begin
    req_valid_o = '0;
    for (int k = 0; k < NUM_TIMERS; k++) begin
      if (head_valid && head_mapped && head_idx == tmr_idx_t'(k) && credit[k] != '0) begin
        req_valid_o[k] = 1'b1;
      end
    end
  end

  assign req_o = head;
  assign fwd   = |req_valid_o;

  // error slot frees up in the cycle the merger takes it
  assign err_free = !err_valid_o || err_pop_i;
  assign err_take = head_valid && !head_mapped && err_free;
  assign pop      = fwd || err_take;

  assign err_rsp_o = '{data: '0, err: 1'b1};

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      buf_cnt       <= '0;
      host_credit_o <= 1'b0;
    end else begin
      if (host_req_valid_i) begin
        wr_ptr <= (wr_ptr == hbuf_ptr_t'(HOST_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == hbuf_ptr_t'(HOST_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({host_req_valid_i, pop})
        2'b10:   buf_cnt <= buf_cnt + 1'b1;
        2'b01:   buf_cnt <= buf_cnt - 1'b1;
        default: buf_cnt <= buf_cnt;
      endcase
      // one credit back to the host per entry leaving the buffer
      host_credit_o <= pop;
    end
  end

  always_ff @(posedge clock) begin
    if (host_req_valid_i) begin
      buf_mem[wr_ptr] <= host_req_i;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      err_valid_o <= 1'b0;
    end else if (err_take) begin
      err_valid_o <= 1'b1;
    end else if (err_pop_i) begin
      err_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      for (int k = 0; k < NUM_TIMERS; k++) begin
        credit[k] <= cred_t'(TIMER_CREDITS);
      end
    end else begin
      for (int k = 0; k < NUM_TIMERS; k++) begin
        case ({req_valid_o[k], credit_ret_i[k]})
          2'b10:   credit[k] <= credit[k] - 1'b1;
          2'b01:   credit[k] <= credit[k] + 1'b1;
          default: credit[k] <= credit[k];
        endcase
      end
    end
  end

endmodule

//--- source/timer_resp_merge.sv
`timescale 1ns/1ps

module timer_resp_merge import periph_pkg::*; (
  input  logic                            clock,
  input  logic                            rst_i,
  input  logic     [NUM_TIMERS-1:0]       rsp_valid_i,
  input  tmr_rsp_t [NUM_TIMERS-1:0]       rsp_i,
  output logic     [NUM_TIMERS-1:0]       rsp_pop_o,
  input  logic                            err_valid_i,
  input  tmr_rsp_t                        err_rsp_i,
  output logic                            err_pop_o,
  output logic                            host_rsp_valid_o,
  output tmr_rsp_t                        host_rsp_o
);

  // source NUM_TIMERS is the decoder error path
  logic     [NUM_SRC-1:0] src_valid;
  tmr_rsp_t [NUM_SRC-1:0] src_rsp;
  logic     [NUM_SRC-1:0] grant;
  src_idx_t               rr_q;
  src_idx_t               sel;
  logic                   found;

  assign src_valid = {err_valid_i, rsp_valid_i};
  assign src_rsp   = {err_rsp_i, rsp_i};

  // first valid source at or after the pointer wins
  always_comb begin
    int unsigned src;
    grant = '0;
    sel   = rr_q;
    found = 1'b0;
    src   = 0;
    for (int unsigned i = 0; i < NUM_SRC; i++) begin
      src = (rr_q + i) % NUM_SRC;
      if (!found && src_valid[src]) begin
        found      = 1'b1;
        sel        = src_idx_t'(src);
        grant[src] = 1'b1;
      end
    end
  end

  // the pop also returns the decoder credit
  assign rsp_pop_o = grant[NUM_TIMERS-1:0];
  assign err_pop_o = grant[NUM_TIMERS];

  always_ff @(posedge clock) begin
    if (rst_i) begin
      rr_q             <= '0;
      host_rsp_valid_o <= 1'b0;
    end else begin
      host_rsp_valid_o <= found;
      if (found) begin
        rr_q <= (sel == src_idx_t'(NUM_SRC - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (found) begin
      host_rsp_o <= src_rsp[sel];
    end
  end

endmodule

//--- source/timer_subsys_top.sv
`timescale 1ns/1ps

module timer_subsys_top import periph_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_i,
  input  logic                  host_req_valid_i,
  input  tmr_req_t              host_req_i,
  output logic                  host_credit_o,
  output logic                  host_rsp_valid_o,
  output tmr_rsp_t              host_rsp_o,
  output logic [NUM_TIMERS-1:0] irq_o
);

  logic     [NUM_TIMERS-1:0] req_valid;
  tmr_req_t                  req;
  logic     [NUM_TIMERS-1:0] rsp_valid;
  tmr_rsp_t [NUM_TIMERS-1:0] rsp;
  logic     [NUM_TIMERS-1:0] rsp_pop;
  logic                      err_valid;
  tmr_rsp_t                  err_rsp;
  logic                      err_pop;

  timer_req_decoder u_decoder (
    .clock            (clock),
    .rst_i            (rst_i),
    .host_req_valid_i (host_req_valid_i),
    .host_req_i       (host_req_i),
    .host_credit_o    (host_credit_o),
    .req_valid_o      (req_valid),
    .req_o            (req),
    .credit_ret_i     (rsp_pop),
    .err_valid_o      (err_valid),
    .err_rsp_o        (err_rsp),
    .err_pop_i        (err_pop)
  );

  // all timers share the request bus, selected by req_valid
  for (genvar k = 0; k < NUM_TIMERS; k++) begin : g_timer
    timer_unit u_timer (
      .clock       (clock),
      .rst_i       (rst_i),
      .req_valid_i (req_valid[k]),
      .req_i       (req),
      .rsp_valid_o (rsp_valid[k]),
      .rsp_o       (rsp[k]),
      .rsp_pop_i   (rsp_pop[k]),
      .irq_o       (irq_o[k])
    );
  end

  timer_resp_merge u_merge (
    .clock            (clock),
    .rst_i            (rst_i),
    .rsp_valid_i      (rsp_valid),
    .rsp_i            (rsp),
    .rsp_pop_o        (rsp_pop),
    .err_valid_i      (err_valid),
    .err_rsp_i        (err_rsp),
    .err_pop_o        (err_pop),
    .host_rsp_valid_o (host_rsp_valid_o),
    .host_rsp_o       (host_rsp_o)
  );

endmodule

//--- source/timer_unit.sv
`timescale 1ns/1ps

module timer_unit import periph_pkg::*; (
  input  logic     clock,
  input  logic     rst_i,
  input  logic     req_valid_i,
  input  tmr_req_t req_i,
  output logic     rsp_valid_o,
  output tmr_rsp_t rsp_o,
  input  logic     rsp_pop_i,
  output logic     irq_o
);

  // timer registers
  data_t    ctrl_q;
  data_t    cmp_q;
  data_t    count_q;
  logic     status_q;

  reg_off_t off;
  logic     wr_en;
  logic     enabled;
  data_t    rd_data;
  tmr_rsp_t push_rsp;

  // response queue sized by the decoder credits
  tmr_rsp_t rq_mem [TIMER_CREDITS];
  rq_ptr_t  rq_wr;
  rq_ptr_t  rq_rd;
  rq_cnt_t  rq_cnt;

  assign off     = addr_off(req_i.addr);
  assign wr_en   = req_valid_i && req_i.write;
  assign enabled = ctrl_q[0];

  always_comb begin
    case (off)
      REG_CTRL:    rd_data = ctrl_q;
      REG_COMPARE: rd_data = cmp_q;
      REG_COUNT:   rd_data = count_q;
      REG_STATUS:  rd_data = {31'b0, status_q};
      default:     rd_data = '0;
    endcase
  end

  // writes answer with zero data
  always_comb begin
    push_rsp.data = req_i.write ? '0 : rd_data;
    push_rsp.err  = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      ctrl_q   <= '0;
      cmp_q    <= '0;
      count_q  <= '0;
      status_q <= 1'b0;
    end else begin
      if (wr_en && off == REG_CTRL) begin
        ctrl_q <= req_i.data;
      end
      if (wr_en && off == REG_COMPARE) begin
        cmp_q <= req_i.data;
      end

      // a count write overrides the increment
      if (wr_en && off == REG_COUNT) begin
        count_q <= req_i.data;
      end else if (enabled) begin
        count_q <= count_q + 1'b1;
      end

      // write-one-to-clear wins over a set in the same cycle
      if (wr_en && off == REG_STATUS && req_i.data[0]) begin
        status_q <= 1'b0;
      end else if (enabled && count_q >= cmp_q) begin
        status_q <= 1'b1;
      end
    end
  end

  assign irq_o = status_q;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      rq_wr  <= '0;
      rq_rd  <= '0;
      rq_cnt <= '0;
    end else begin
      if (req_valid_i) begin
        rq_wr <= (rq_wr == rq_ptr_t'(TIMER_CREDITS - 1)) ? '0 : rq_wr + 1'b1;
      end
      if (rsp_pop_i) begin
        rq_rd <= (rq_rd == rq_ptr_t'(TIMER_CREDITS - 1)) ? '0 : rq_rd + 1'b1;
      end
      case ({req_valid_i, rsp_pop_i})
        2'b10:   rq_cnt <= rq_cnt + 1'b1;
        2'b01:   rq_cnt <= rq_cnt - 1'b1;
        default: rq_cnt <= rq_cnt;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid_i) begin
      rq_mem[rq_wr] <= push_rsp;
    end
  end

  // head of queue goes straight to the merger
  assign rsp_valid_o = (rq_cnt != '0);
  assign rsp_o       = rq_mem[rq_rd];

endmodule
